//--- dv/snes_mem_assertions.sv
// sdram command port checks
`timescale 1ns/100ps

module snes_mem_assertions (
    input logic                       wclk,
    input logic                       resetn,
    input sdram_port_pkg::sdram_cmd_t cmd
);

    // one kind of command at a time
    rd_wr_exclusive: assert property (
        @(posedge wclk) disable iff (!resetn)
        !(cmd.rd && cmd.wr)
    ) else $error("read and write pulses high in the same cycle");

    // reset clears the command register
    idle_after_reset: assert property (
        @(posedge wclk)
        !resetn |=> !(cmd.rd || cmd.wr)
    ) else $error("command active in the cycle after reset");

    // port bit only with a live command
    port_with_cmd: assert property (
        @(posedge wclk) disable iff (!resetn)
        cmd.port |-> (cmd.rd || cmd.wr)
    ) else $error("port bit set without a read or a write");

endmodule

//--- dv/snes_mem_tests.svh
// directed tests for the snes memory path
`ifndef SNES_MEM_TESTS_SVH
`define SNES_MEM_TESTS_SVH

task automatic step();
    @(posedge wclk);
    #10;   // inputs move well clear of the edge
endtask

task automatic fail_now(input string msg);
    $display("MISMATCH at %0d ns: %s", $time, msg);
    $display("Done: errors found");
    $fatal(1, "stopping at the first mismatch");
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
    assert (got === exp)
    else fail_now($sformatf("%s got %b expected %b", what, got, exp));
endtask

task automatic check_word(input logic [15:0] got, input logic [15:0] exp, input string what);
    assert (got === exp)
    else fail_now($sformatf("%s got %h expected %h", what, got, exp));
endtask

// data field counts only for writes
task automatic check_cmd(input sdram_cmd_t exp, input string what);
    assert (cmd.rd === exp.rd && cmd.wr === exp.wr && cmd.port === exp.port &&
            cmd.ds === exp.ds && cmd.addr === exp.addr &&
            (!exp.wr || cmd.data === exp.data))
    else fail_now($sformatf("%s got addr %h data %h ds %b port %b rd %b wr %b, %s",
                            what, cmd.addr, cmd.data, cmd.ds, cmd.port, cmd.rd, cmd.wr,
                            $sformatf("expected addr %h data %h ds %b port %b rd %b wr %b",
                                      exp.addr, exp.data, exp.ds, exp.port, exp.rd,
                                      exp.wr)));
endtask

task automatic check_idle(input string what);
    check_bit(cmd.rd, 1'b0, {what, ", cmd.rd"});
    check_bit(cmd.wr, 1'b0, {what, ", cmd.wr"});
endtask

function automatic logic [1:0] lane_mask(input logic a0);
    return a0 ? 2'b10 : 2'b01;   // odd byte on the high lane
endfunction

function automatic sdram_cmd_t make_cmd(input logic [23:0] addr, input logic [15:0] data,
                                        input logic [1:0] ds, input logic port,
                                        input logic rd, input logic wr);
    sdram_cmd_t c;
    c      = '0;
    c.addr = addr;
    c.data = data;
    c.ds   = ds;
    c.port = port;
    c.rd   = rd;
    c.wr   = wr;
    return c;
endfunction

task automatic test_enable_gating();
    int i;
    check_bit(enable, 1'b1, "enable after reset");
    for (i = 0; i < 3; i++) begin
        sdram_busy  = (i == 0);
        loader_fail = (i == 1);
        frame_pause = (i == 2);
        step();
        check_bit(enable, 1'b0, "enable with a level high");
        sdram_busy  = 1'b0;
        loader_fail = 1'b0;
        frame_pause = 1'b0;
        step();
        check_bit(enable, 1'b1, "enable with all levels low");
    end
    // rom request held against a stalled core
    sdram_busy   = 1'b1;
    step();
    rom_req.addr = 24'($urandom);
    rom_req.ce   = 1'b1;
    rom_req.word = 1'b1;
    for (i = 0; i < 6; i++) begin
        sysclkf_ce = ~sysclkf_ce;   // strobe every other cycle
        step();
        check_bit(cmd.rd, 1'b0, "rom read with enable low");
    end
    sysclkf_ce      = 1'b0;
    loading         = 1'b1;         // loader ignores enable
    load_byte.data  = 8'($urandom);
    load_byte.valid = 1'b1;
    step();
    check_bit(cmd.wr, 1'b1, "loader write with enable low");
    load_byte.valid = 1'b0;
    loading         = 1'b0;
    rom_req.ce      = 1'b0;
    sdram_busy      = 1'b0;
    step();
    check_idle("after stalled loader write");
    check_bit(enable, 1'b1, "enable back up");
endtask

task automatic test_loader_writes();
    logic [7:0] bytes[$];
    logic [7:0] b;
    int         n;
    int         i;
    n = 6 + int'($urandom % 5);
    wr_log.delete();
    loading = 1'b1;   // rise restarts the counter
    for (i = 0; i < n; i++) begin
        b = 8'($urandom);
        bytes.push_back(b);
        load_byte.data  = b;
        load_byte.valid = 1'b1;
        step();
        check_cmd(make_cmd(24'(i), {b, b}, lane_mask(i[0]), 1'b0, 1'b0, 1'b1),
                  "loader write");
        load_byte.valid = 1'b0;
        step();
        check_idle("loader write lasts one cycle");
    end
    check_word(16'(wr_log.size()), 16'(n), "logged loader writes");
    for (i = 0; i < n; i++) begin
        check_word(16'(wr_log[i].addr), 16'(i), "logged write address");
        check_word(wr_log[i].data, {bytes[i], bytes[i]}, "logged write data");
    end
    loading = 1'b0;
    step();
    b               = 8'($urandom);
    loading         = 1'b1;   // second load
    load_byte.data  = b;
    load_byte.valid = 1'b1;
    step();
    check_cmd(make_cmd(24'h0, {b, b}, 2'b01, 1'b0, 1'b0, 1'b1), "second load at address 0");
    load_byte.valid = 1'b0;
    loading         = 1'b0;
    step();
    check_idle("after second load");
endtask

task automatic issue_rom_read(input logic [23:0] addr, input logic word);
    logic [15:0] p;
    logic [15:0] exp_q;
    rom_req.addr = addr;
    rom_req.ce   = 1'b1;
    rom_req.word = word;
    sysclkf_ce   = 1'b1;
    step();                 // f2 set here
    sysclkf_ce = 1'b0;
    check_idle("one cycle after the fall strobe");
    step();
    check_cmd(make_cmd(addr, 16'h0, 2'b11, 1'b0, 1'b1, 1'b0), "rom read");
    rom_req.ce = 1'b0;
    step();
    check_idle("rom read lasts one cycle");
    #40;                    // responder has driven port0_q
    p     = mem_pattern(addr);
    exp_q = (word || !addr[0]) ? p : {p[7:0], p[15:8]};
    check_word(rom_q, exp_q, "rom_q");
    step();
    check_word(rom_q, exp_q, "rom_q held");
endtask

task automatic test_rom_read();
    int i;
    issue_rom_read(24'($urandom) & 24'hfffffe, 1'b1);
    issue_rom_read(24'($urandom) & 24'hfffffe, 1'b0);
    issue_rom_read(24'($urandom) | 24'h000001, 1'b0);   // odd byte gets swapped
    issue_rom_read(24'($urandom) | 24'h000001, 1'b1);   // word never swaps
    for (i = 0; i < 4; i++) begin
        issue_rom_read(24'($urandom), 1'($urandom));
    end
endtask

task automatic issue_wram_access(input logic [16:0] addr, input logic wr,
                                 input logic [7:0] data);
    logic [15:0] p;
    logic [7:0]  exp_b;
    wram_req      = '0;
    wram_req.addr = addr;
    wram_req.sel  = 1'b1;
    wram_req.rd   = ~wr;
    wram_req.wr   = wr;
    wram_req.data = data;
    sysclkf_ce    = ~wr;   // reads on the fall strobe and writes on the rise strobe
    sysclkr_ce    = wr;
    step();
    sysclkf_ce = 1'b0;
    sysclkr_ce = 1'b0;
    check_idle("one cycle after the wram strobe");
    step();
    check_cmd(make_cmd({wram_base, addr}, {data, data}, lane_mask(addr[0]), 1'b1, ~wr, wr),
              "wram command");
    wram_req = '0;
    step();
    check_idle("wram command lasts one cycle");
    if (!wr) begin
        #40;
        p     = mem_pattern({wram_base, addr});
        exp_b = addr[0] ? p[15:8] : p[7:0];
        check_word({8'h00, wram_q}, {8'h00, exp_b}, "wram_q");
    end
endtask

task automatic test_wram_access();
    int i;
    wram_req      = '0;
    wram_req.addr = 17'($urandom);
    wram_req.sel  = 1'b1;
    wram_req.rd   = 1'b1;
    for (i = 0; i < 3; i++) begin
        step();
        check_idle("wram read without strobe");
    end
    for (i = 0; i < 4; i++) begin
        issue_wram_access({16'($urandom), i[0]}, 1'b0, 8'h00);
        issue_wram_access({16'($urandom), i[0]}, 1'b1, 8'($urandom));
    end
endtask

task automatic test_priority();
    logic [23:0] ra;
    logic [7:0]  b;
    ra              = 24'($urandom);
    b               = 8'($urandom);
    rom_req.addr    = ra;
    rom_req.ce      = 1'b1;
    rom_req.word    = 1'b1;
    wram_req        = '0;
    wram_req.addr   = 17'($urandom);
    wram_req.sel    = 1'b1;
    wram_req.rd     = 1'b1;
    loading         = 1'b1;   // fresh load from 0
    sysclkf_ce      = 1'b1;
    step();
    sysclkf_ce      = 1'b0;
    load_byte.data  = b;      // lands together with f2
    load_byte.valid = 1'b1;
    step();
    check_cmd(make_cmd(24'h0, {b, b}, 2'b01, 1'b0, 1'b0, 1'b1), "loader over rom and wram");
    load_byte.valid = 1'b0;
    loading         = 1'b0;
    step();
    check_idle("lost rom and wram reads");
    sysclkf_ce = 1'b1;        // same without the loader
    step();
    sysclkf_ce = 1'b0;
    step();
    check_cmd(make_cmd(ra, 16'h0, 2'b11, 1'b0, 1'b1, 1'b0), "rom over wram");
    rom_req.ce = 1'b0;
    wram_req   = '0;
    step();
    check_idle("no wram read after rom");
endtask

`endif

//--- dv/tb_snes_mem.sv
// snes memory path testbench
`timescale 1ns/100ps

module tb_snes_mem;
    import snes_bus_pkg::*;
    import sdram_port_pkg::*;

    localparam int         addr_w          = 24;
    localparam logic [6:0] wram_base       = 7'b1110111;   // wram at EE0000
    localparam int         clk_period      = 100;
    localparam int         num_tests       = 5;
    localparam int         cycles_per_test = 200;          // longest test needs about 60
    localparam int         seed            = 25812;

    logic        wclk;
    logic        resetn;
    logic        sdram_busy;
    logic        loader_fail;
    logic        frame_pause;
    logic        sysclkf_ce;
    logic        sysclkr_ce;
    logic        loading;
    load_byte_t  load_byte;
    rom_req_t    rom_req;
    wram_req_t   wram_req;
    logic [15:0] port0_q;
    logic [15:0] port1_q;
    logic        enable;
    sdram_cmd_t  cmd;
    logic [15:0] rom_q;
    logic [7:0]  wram_q;

    sdram_cmd_t  wr_log[$];   // writes seen by the responder
    logic        rd_pend;     // read issued in the last cycle
    sdram_cmd_t  rd_cmd;      // and its command

    snes_mem_top #(
        .addr_w    (addr_w),
        .wram_base (wram_base)
    ) u_snes_mem_top (
        .wclk        (wclk),
        .resetn      (resetn),
        .sdram_busy  (sdram_busy),
        .loader_fail (loader_fail),
        .frame_pause (frame_pause),
        .sysclkf_ce  (sysclkf_ce),
        .sysclkr_ce  (sysclkr_ce),
        .loading     (loading),
        .load_byte   (load_byte),
        .rom_req     (rom_req),
        .wram_req    (wram_req),
        .port0_q     (port0_q),
        .port1_q     (port1_q),
        .enable      (enable),
        .cmd         (cmd),
        .rom_q       (rom_q),
        .wram_q      (wram_q)
    );

    bind sdram_cmd_issue snes_mem_assertions u_assert (
        .wclk   (wclk),
        .resetn (resetn),
        .cmd    (cmd)
    );

    // sdram contents as a fixed function of every address bit
    function automatic logic [15:0] mem_pattern(input logic [23:0] addr);
        return addr[15:0] ^ {addr[23:16], ~addr[23:16]} ^ 16'h3c5a;
    endfunction

    `include "snes_mem_tests.svh"

    initial begin
        wclk = 1'b0;
        forever #(clk_period / 2) wclk = ~wclk;
    end

    // sdram responder drives data on the cycle after a read
    initial begin
        port0_q = '0;
        port1_q = '0;
        rd_pend = 1'b0;
        rd_cmd  = '0;
        forever begin
            @(posedge wclk);
            #10;
            if (rd_pend) begin
                if (rd_cmd.port) begin
                    port1_q = mem_pattern(rd_cmd.addr);   // wram port
                end else begin
                    port0_q = mem_pattern(rd_cmd.addr);
                end
            end
            rd_pend = cmd.rd;
            rd_cmd  = cmd;
            if (cmd.wr) begin
                wr_log.push_back(cmd);
            end
        end
    end

    // watchdog sized from the test count
    initial begin
        #(clk_period * (num_tests * cycles_per_test + 10));
        $display("ERROR: watchdog expired, the tests did not finish in time");
        $display("Done: errors found");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        void'($urandom(seed));
        resetn      = 1'b0;
        sdram_busy  = 1'b0;
        loader_fail = 1'b0;
        frame_pause = 1'b0;
        sysclkf_ce  = 1'b0;
        sysclkr_ce  = 1'b0;
        loading     = 1'b0;
        load_byte   = '0;
        rom_req     = '0;
        wram_req    = '0;
        repeat (3) @(posedge wclk);   // reset held 3 cycles
        #10;
        check_bit(enable, 1'b0, "enable in reset");
        check_bit(cmd.rd, 1'b0, "cmd.rd in reset");
        check_bit(cmd.wr, 1'b0, "cmd.wr in reset");
        resetn = 1'b1;
        step();                       // enable comes up here
        test_enable_gating();
        test_loader_writes();
        test_rom_read();
        test_wram_access();
        test_priority();
        step();
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the snes memory path testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_snes_mem -f tb.f

status=0
./obj_dir/Vtb_snes_mem > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Done: errors found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "simulation passed"

//--- src/mem_req_decode.sv
// snes memory request decode
`timescale 1ns/100ps

module mem_req_decode #(
    parameter int         addr_w    = 24,
    parameter logic [6:0] wram_base = 7'b1110111
) (
    input  logic                     wclk,
    input  logic                     resetn,
    input  logic                     sdram_busy,
    input  logic                     loader_fail,
    input  logic                     frame_pause,
    input  logic                     sysclkf_ce,
    input  logic                     sysclkr_ce,
    input  logic                     loading,
    input  snes_bus_pkg::load_byte_t load_byte,
    input  snes_bus_pkg::rom_req_t   rom_req,
    input  snes_bus_pkg::wram_req_t  wram_req,
    output logic                     enable,
    output snes_bus_pkg::mem_req_t   req
);
    import snes_bus_pkg::*;

    logic              f2;              // fall strobe, registered
    logic              r2;              // rise strobe, registered
    logic              loading_r;
    logic [addr_w-1:0] load_addr;       // next loader byte address
    logic [addr_w-1:0] load_addr_cur;   // address used this cycle
    logic              load_rise;
    logic              load_wr;
    logic              rom_rd;
    logic              wram_rd;
    logic              wram_wr;

    // start of a new load restarts at address 0
    assign load_rise     = loading & ~loading_r;
    assign load_addr_cur = load_rise ? '0 : load_addr;

    assign load_wr = loading & load_byte.valid;
    assign rom_rd  = rom_req.ce & f2 & enable;                  // reads on fall strobe
    assign wram_rd = wram_req.sel & wram_req.rd & f2 & enable;
    assign wram_wr = wram_req.sel & wram_req.wr & r2 & enable;  // writes on rise strobe

    always_ff @(posedge wclk) begin
        if (!resetn) begin
            enable    <= 1'b0;
            f2        <= 1'b0;
            r2        <= 1'b0;
            loading_r <= 1'b0;
            load_addr <= '0;
        end else begin
            // core runs only while memory is ready and no pause is pending
            enable    <= ~(sdram_busy | loader_fail | frame_pause);
            f2        <= sysclkf_ce & enable;
            r2        <= sysclkr_ce & enable;
            loading_r <= loading;
            if (load_wr) begin
                load_addr <= load_addr_cur + addr_w'(1);   // post increment
            end else if (load_rise) begin
                load_addr <= '0;
            end
        end
    end

    // one request per cycle, loader first, then rom, then wram
    always_comb begin
        req      = '0;
        req.op   = op_none;
        if (load_wr) begin
            req.op   = op_load_wr;
            req.addr = 24'(load_addr_cur);
            req.data = {load_byte.data, load_byte.data};   // byte on both lanes
            req.a0   = load_addr_cur[0];
        end else if (rom_rd) begin
            req.op   = op_rom_rd;
            req.addr = rom_req.addr;
            req.word = rom_req.word;
            req.a0   = rom_req.addr[0];
        end else if (wram_rd || wram_wr) begin
            req.op   = wram_rd ? op_wram_rd : op_wram_wr;
            req.addr = 24'({wram_base, wram_req.addr});    // EE0000-EFFFFF by default
            req.data = {wram_req.data, wram_req.data};
            req.a0   = wram_req.addr[0];
        end
    end

endmodule

//--- src/read_data_steer.sv
// sdram read data steering
`timescale 1ns/100ps

module read_data_steer (
    input  logic                      wclk,
    input  logic                      resetn,
    input  logic                      cmd_rd,
    input  sdram_port_pkg::lane_sel_t issued_lane,
    input  logic [15:0]               port0_q,
    input  logic [15:0]               port1_q,
    output logic [15:0]               rom_q,
    output logic [7:0]                wram_q
);
    import sdram_port_pkg::*;

    lane_sel_t rom_lane;    // lane of the last rom read
    lane_sel_t wram_lane;   // lane of the last wram read

    // each port keeps its own lane so outputs hold across reads of the other
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            rom_lane  <= '0;
            wram_lane <= '0;
        end else if (cmd_rd) begin
            if (issued_lane.port) begin
                wram_lane <= issued_lane;
            end else begin
                rom_lane <= issued_lane;
            end
        end
    end

    // odd byte access gets the high byte moved down
    assign rom_q = (rom_lane.word || !rom_lane.a0) ? port0_q
                                                   : {port0_q[7:0], port0_q[15:8]};

    assign wram_q = wram_lane.a0 ? port1_q[15:8] : port1_q[7:0];   // byte by bit 0

endmodule

//--- src/sdram_cmd_issue.sv
// sdram command register
`timescale 1ns/100ps

module sdram_cmd_issue #(
    parameter int addr_w = 24
) (
    input  logic                      wclk,
    input  logic                      resetn,
    input  snes_bus_pkg::mem_req_t    req,
    output sdram_port_pkg::sdram_cmd_t cmd,
    output sdram_port_pkg::lane_sel_t  issued_lane
);
    import snes_bus_pkg::*;
    import sdram_port_pkg::*;

    // drops address bits above the sdram size
    localparam logic [23:0] addr_mask = 24'((64'd1 << addr_w) - 64'd1);

    sdram_cmd_t cmd_d;
    lane_sel_t  lane_d;
    logic [1:0] lane_ds;   // single byte lane from bit 0

    assign lane_ds = {req.a0, ~req.a0};

    always_comb begin
        cmd_d  = '0;       // op_none leaves everything low
        lane_d = '0;
        case (req.op)
            op_load_wr: begin
                cmd_d.wr   = 1'b1;
                cmd_d.data = req.data;
                cmd_d.ds   = lane_ds;
            end
            op_rom_rd: begin
                cmd_d.rd = 1'b1;
                cmd_d.ds = ds_both;   // full word, steer picks the byte
            end
            op_wram_rd: begin
                cmd_d.rd   = 1'b1;
                cmd_d.port = 1'b1;
                cmd_d.ds   = lane_ds;
            end
            op_wram_wr: begin
                cmd_d.wr   = 1'b1;
                cmd_d.port = 1'b1;
                cmd_d.data = req.data;
                cmd_d.ds   = lane_ds;
            end
            default: begin
            end
        endcase
        if (req.op != op_none) begin
            cmd_d.addr  = req.addr & addr_mask;
            lane_d.port = cmd_d.port;
            lane_d.word = req.word;
            lane_d.a0   = req.a0;
        end
    end

    // every command lasts exactly one cycle
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            cmd         <= '0;
            issued_lane <= '0;
        end else begin
            cmd         <= cmd_d;
            issued_lane <= lane_d;   // meaningful only with cmd.rd
        end
    end

endmodule

//--- src/sdram_port_pkg.sv
// sdram command port types
package sdram_port_pkg;

    // one sdram command, valid for a single wclk cycle
    typedef struct packed {
        logic [23:0] addr;   // byte address
        logic [15:0] data;   // write data
        logic [1:0]  ds;     // byte lane mask, bit 1 = high byte
        logic        port;   // 0 rom/loader, 1 wram
        logic        rd;     // read pulse
        logic        wr;     // write pulse
    } sdram_cmd_t;

    // lane info of a pending read
    typedef struct packed {
        logic port;          // which port the data returns on
        logic word;          // rom word access, no swap
        logic a0;            // odd byte address
    } lane_sel_t;

    // both lanes, used by 16-bit rom reads
    localparam logic [1:0] ds_both = 2'b11;

endpackage

//--- src/snes_bus_pkg.sv
// snes side bus types
package snes_bus_pkg;

    // rom bus as the sdram side sees it
    typedef struct packed {
        logic [23:0] addr;   // byte address from the cartridge mapper
        logic        ce;     // chip enable, active high
        logic        word;   // 16-bit access
    } rom_req_t;

    // work ram bus, 128KB
    typedef struct packed {
        logic [16:0] addr;
        logic        sel;    // wram selected
        logic        rd;     // read level
        logic        wr;     // write level
        logic [7:0]  data;   // write byte
    } wram_req_t;

    // one byte from the rom loader
    typedef struct packed {
        logic [7:0] data;
        logic       valid;   // one cycle pulse
    } load_byte_t;

    // request opcode, none must stay at zero
    typedef enum logic [2:0] {
        op_none    = 3'd0,
        op_load_wr = 3'd1,   // loader byte into rom space
        op_rom_rd  = 3'd2,
        op_wram_rd = 3'd3,
        op_wram_wr = 3'd4
    } mem_op_e;

    // decoded request handed to the command stage
    typedef struct packed {
        mem_op_e     op;
        logic [23:0] addr;   // sdram byte address
        logic [15:0] data;   // write data, byte already duplicated
        logic        word;   // rom word access
        logic        a0;     // byte address bit 0, picks the lane
    } mem_req_t;

endpackage

//--- src/snes_mem_top.sv
// snes sdram request path
`timescale 1ns/100ps

module snes_mem_top #(
    parameter int         addr_w    = 24,
    parameter logic [6:0] wram_base = 7'b1110111
) (
    input  logic                       wclk,
    input  logic                       resetn,
    input  logic                       sdram_busy,
    input  logic                       loader_fail,
    input  logic                       frame_pause,
    input  logic                       sysclkf_ce,
    input  logic                       sysclkr_ce,
    input  logic                       loading,
    input  snes_bus_pkg::load_byte_t   load_byte,
    input  snes_bus_pkg::rom_req_t     rom_req,
    input  snes_bus_pkg::wram_req_t    wram_req,
    input  logic [15:0]                port0_q,
    input  logic [15:0]                port1_q,
    output logic                       enable,
    output sdram_port_pkg::sdram_cmd_t cmd,
    output logic [15:0]                rom_q,
    output logic [7:0]                 wram_q
);
    import snes_bus_pkg::*;
    import sdram_port_pkg::*;

    mem_req_t  req;           // decoded request, one per cycle
    lane_sel_t issued_lane;   // lane of the command in flight

    mem_req_decode #(
        .addr_w    (addr_w),
        .wram_base (wram_base)
    ) u_decode (
        .wclk        (wclk),
        .resetn      (resetn),
        .sdram_busy  (sdram_busy),
        .loader_fail (loader_fail),
        .frame_pause (frame_pause),
        .sysclkf_ce  (sysclkf_ce),
        .sysclkr_ce  (sysclkr_ce),
        .loading     (loading),
        .load_byte   (load_byte),
        .rom_req     (rom_req),
        .wram_req    (wram_req),
        .enable      (enable),
        .req         (req)
    );

    sdram_cmd_issue #(
        .addr_w (addr_w)
    ) u_issue (
        .wclk        (wclk),
        .resetn      (resetn),
        .req         (req),
        .cmd         (cmd),
        .issued_lane (issued_lane)
    );

    read_data_steer u_steer (
        .wclk        (wclk),
        .resetn      (resetn),
        .cmd_rd      (cmd.rd),
        .issued_lane (issued_lane),
        .port0_q     (port0_q),
        .port1_q     (port1_q),
        .rom_q       (rom_q),
        .wram_q      (wram_q)
    );

endmodule

//--- tb.f
+incdir+dv
src/snes_bus_pkg.sv
src/sdram_port_pkg.sv
src/mem_req_decode.sv
src/sdram_cmd_issue.sv
src/read_data_steer.sv
src/snes_mem_top.sv
dv/snes_mem_assertions.sv
dv/tb_snes_mem.sv
